/* compile.f */
+incdir+.
out_types_pkg.sv
out_geom_pkg.sv
out_ctrl_if.sv
pixel_fifo.sv
out_cfg_regs.sv
out_frame_ram.sv
output_handling.sv
output_stage_top.sv
tb_output_stage.sv

/* out_cfg_regs.sv */
`timescale 1ns/10ps

module out_cfg_regs
	import out_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic cfg_write,
	input cfg_reg_e cfg_addr,
	input logic [reg_width-1:0] cfg_wdata,
	output logic [reg_width-1:0] cfg_rdata,
	out_ctrl_if.cfg ctrl
);

	logic signed [pixel_width-1:0] threshold;
	logic restart;
	logic restart_cmd;

	// Bit 0 of the control register requests a new frame
	assign restart_cmd = cfg_write && (cfg_addr == reg_control) && cfg_wdata[0];

	always_ff @(posedge clk) begin
		if (reset) begin
			threshold <= threshold_reset;
			restart <= 1'b0;
		end else begin
			if (cfg_write && (cfg_addr == reg_threshold))
				threshold <= $signed(cfg_wdata);
			// Single cycle pulse, the command bit is not stored
			restart <= restart_cmd;
		end
	end

	assign ctrl.threshold = threshold;
	assign ctrl.frame_restart = restart;

	////////////////////
	// Readback
	always_comb begin
		case (cfg_addr)
			reg_threshold: cfg_rdata = threshold;
			reg_control: cfg_rdata = '0;
			reg_status: begin
				cfg_rdata = {
					ctrl.pixels_written,
					{(reg_width - pixel_count_width - 1){1'b0}},
					ctrl.frame_ready
				};
			end
			default: cfg_rdata = '0;
		endcase
	end

endmodule

/* out_ctrl_if.sv */
`timescale 1ns/10ps

interface out_ctrl_if
	import out_types_pkg::*;
();

	logic signed [pixel_width-1:0] threshold;
	logic frame_restart;

	// Handler status
	logic frame_ready;
	logic [pixel_count_width-1:0] pixels_written;

	modport cfg (
		output threshold,
		output frame_restart,
		input frame_ready,
		input pixels_written
	);

	modport handler (
		input threshold,
		input frame_restart,
		output frame_ready,
		output pixels_written
	);

endinterface

/* out_frame_ram.sv */
`timescale 1ns/10ps

module out_frame_ram
	import out_types_pkg::*;
	import out_geom_pkg::*;
(
	input logic clk,
	input logic write,
	input logic [ram_addr_width-1:0] addr,
	input logic [ram_data_width-1:0] write_data,
	output logic [ram_data_width-1:0] read_data
);

	logic [ram_data_width-1:0] mem [ram_words];
	logic [ram_index_width-1:0] index;

	// Frame fits in the low word addresses
	assign index = addr[ram_index_width-1:0];

	always_ff @(posedge clk) begin
		if (write)
			mem[index] <= write_data;
		read_data <= mem[index];
	end

endmodule

/* out_geom_pkg.sv */
package out_geom_pkg;

	////////////////////
	// Frame size in pixels
	localparam int frame_width = 64;
	localparam int frame_height = 16;
	localparam int frame_border = 1;

	localparam int row_pixels = frame_width - 2 * frame_border;
	localparam int frame_pixels = row_pixels * (frame_height - 2 * frame_border);
	// Jump from the last interior pixel over both borders
	localparam int row_skip = 2 * frame_border + 1;

	////////////////////
	// Pixel and RAM addressing
	localparam int ram_addr_width = 16;
	localparam int lane_bits = 3;
	localparam int pixel_addr_width = ram_addr_width + lane_bits;
	localparam int ram_words = 128;
	localparam int ram_index_width = $clog2(ram_words);

	localparam logic [pixel_addr_width-1:0] frame_start_addr =
		pixel_addr_width'(frame_width + frame_border);
	localparam logic [pixel_addr_width-1:0] frame_end_addr =
		pixel_addr_width'((frame_height - 1) * frame_width + frame_border);

	// Position inside a row
	localparam int row_count_width = $clog2(row_pixels);
	localparam logic [row_count_width-1:0] row_last = row_count_width'(row_pixels - 1);

endpackage

/* out_types_pkg.sv */
package out_types_pkg;

	////////////////////
	// Data widths
	localparam int pixel_width = 32;
	localparam int ram_data_width = 64;
	localparam int byte_width = 8;
	localparam int reg_width = 32;
	localparam int pixel_count_width = 16;

	// Pixel FIFO size
	localparam int fifo_depth = 16;
	localparam int fifo_ptr_width = $clog2(fifo_depth);

	localparam logic signed [pixel_width-1:0] threshold_reset = 128;

	////////////////////
	// Register map
	typedef enum logic [1:0] {
		reg_threshold = 2'd0,
		reg_control = 2'd1,
		reg_status = 2'd2
	} cfg_reg_e;

	typedef enum logic [1:0] {
		frame_fill,
		frame_done
	} frame_state_e;

endpackage

/* output_handling.sv */
`timescale 1ns/10ps

module output_handling
	import out_types_pkg::*;
	import out_geom_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic fifo_empty,
	input logic signed [pixel_width-1:0] fifo_data,
	output logic fifo_read,
	out_ctrl_if.handler ctrl,
	input logic [ram_addr_width-1:0] ram_read_addr,
	output logic [ram_data_width-1:0] ram_read_data
);

	frame_state_e state;
	logic [pixel_addr_width-1:0] pix_addr;
	logic [pixel_addr_width-1:0] next_addr;
	logic [row_count_width-1:0] row_count;
	logic [ram_data_width-1:0] pack;
	logic [ram_data_width-1:0] write_word;
	logic [pixel_count_width-1:0] pixels_written;
	logic [lane_bits-1:0] lane;

	// Pipeline from pop to RAM write
	logic data_valid;
	logic write_valid;
	logic [byte_width-1:0] pixel_byte;

	logic ram_write;
	logic [ram_addr_width-1:0] ram_addr;

	assign fifo_read = !fifo_empty && (state == frame_fill);

	////////////////////
	// Pop and threshold stages
	always_ff @(posedge clk) begin
		if (reset || ctrl.frame_restart) begin
			data_valid <= 1'b0;
			write_valid <= 1'b0;
		end else begin
			data_valid <= fifo_read;
			write_valid <= data_valid;
		end
	end

	// Signed compare, result becomes a full white or black byte
	always_ff @(posedge clk) begin
		if (data_valid)
			pixel_byte <= (fifo_data > ctrl.threshold) ? '1 : '0;
	end

	////////////////////
	// Byte packing
	assign lane = pix_addr[lane_bits-1:0];

	always_comb begin
		write_word = pack;
		write_word[lane * byte_width +: byte_width] = pixel_byte;
	end

	// Skip the right and left border at the end of a row
	assign next_addr = (row_count == row_last) ?
		pix_addr + pixel_addr_width'(row_skip) : pix_addr + 1'b1;

	assign ram_write = write_valid && (state == frame_fill);

	always_ff @(posedge clk) begin
		if (reset || ctrl.frame_restart) begin
			pix_addr <= frame_start_addr;
			row_count <= '0;
			pack <= '0;
			pixels_written <= '0;
		end else if (ram_write) begin
			pix_addr <= next_addr;
			pixels_written <= pixels_written + 1'b1;
			if (row_count == row_last)
				row_count <= '0;
			else
				row_count <= row_count + 1'b1;
			// Untouched lanes of a new word stay zero
			if (next_addr[pixel_addr_width-1:lane_bits] != pix_addr[pixel_addr_width-1:lane_bits])
				pack <= '0;
			else
				pack <= write_word;
		end
	end

	////////////////////
	// Frame state
	always_ff @(posedge clk) begin
		if (reset || ctrl.frame_restart)
			state <= frame_fill;
		else if ((state == frame_fill) && (pix_addr >= frame_end_addr))
			state <= frame_done;
	end

	assign ctrl.frame_ready = (state == frame_done);
	assign ctrl.pixels_written = pixels_written;

	// Reader owns the RAM once the frame is done
	assign ram_addr = ctrl.frame_ready ?
		ram_read_addr : pix_addr[pixel_addr_width-1:lane_bits];

	out_frame_ram u_frame_ram (
		.clk(clk),
		.write(ram_write),
		.addr(ram_addr),
		.write_data(write_word),
		.read_data(ram_read_data)
	);

endmodule

/* output_stage_top.sv */
`timescale 1ns/10ps

module output_stage_top
	import out_types_pkg::*;
	import out_geom_pkg::*;
(
	input logic clk,
	input logic reset,

	// Filter result stream
	input logic pixel_push,
	input logic signed [pixel_width-1:0] pixel_data,
	output logic pixel_full,

	// Configuration access
	input logic cfg_write,
	input logic [$bits(cfg_reg_e)-1:0] cfg_addr,
	input logic [reg_width-1:0] cfg_wdata,
	output logic [reg_width-1:0] cfg_rdata,

	// Frame readout
	output logic frame_ready,
	input logic [ram_addr_width-1:0] ram_read_addr,
	output logic [ram_data_width-1:0] ram_read_data
);

	logic fifo_empty;
	logic fifo_read;
	logic signed [pixel_width-1:0] fifo_data;

	out_ctrl_if ctrl_if ();

	////////////////////
	// Input buffer, flushed on restart
	pixel_fifo u_pixel_fifo (
		.clk(clk),
		.reset(reset),
		.flush(ctrl_if.frame_restart),
		.push(pixel_push),
		.push_data(pixel_data),
		.full(pixel_full),
		.read(fifo_read),
		.empty(fifo_empty),
		.read_data(fifo_data)
	);

	out_cfg_regs u_cfg_regs (
		.clk(clk),
		.reset(reset),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_reg_e'(cfg_addr)),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.ctrl(ctrl_if.cfg)
	);

	////////////////////
	// Threshold, packing and frame RAM
	output_handling u_output_handling (
		.clk(clk),
		.reset(reset),
		.fifo_empty(fifo_empty),
		.fifo_data(fifo_data),
		.fifo_read(fifo_read),
		.ctrl(ctrl_if.handler),
		.ram_read_addr(ram_read_addr),
		.ram_read_data(ram_read_data)
	);

	assign frame_ready = ctrl_if.frame_ready;

endmodule

/* pixel_fifo.sv */
`timescale 1ns/10ps

module pixel_fifo
	import out_types_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic flush,
	input logic push,
	input logic signed [pixel_width-1:0] push_data,
	output logic full,
	input logic read,
	output logic empty,
	output logic signed [pixel_width-1:0] read_data
);

	logic signed [pixel_width-1:0] mem [fifo_depth];
	logic [fifo_ptr_width-1:0] wr_ptr;
	logic [fifo_ptr_width-1:0] rd_ptr;
	logic [fifo_ptr_width:0] count;
	logic do_push;
	logic do_read;

	assign full = (count == (fifo_ptr_width + 1)'(fifo_depth));
	assign empty = (count == '0);

	// Pushes while full and reads while empty are dropped
	assign do_push = push && !full;
	assign do_read = read && !empty;

	////////////////////
	// Pointers and fill level
	always_ff @(posedge clk) begin
		if (reset || flush) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_read})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////
	// Storage, read data one cycle after read
	always_ff @(posedge clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
		if (do_read)
			read_data <= mem[rd_ptr];
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the output stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=sim_tb_output_stage

verilator --binary --timing -f compile.f --top-module tb_output_stage -o "$BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build returned status $status"
	exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

grep -q "Simulation failed" "$LOG"
status=$?
if [ $status -eq 0 ]; then
	exit 1
fi
if [ $status -ne 1 ]; then
	echo "Could not search $LOG"
	exit 1
fi
exit 0

/* tb_output_model.svh */
`ifndef TB_OUTPUT_MODEL_SVH
`define TB_OUTPUT_MODEL_SVH

////////////////////
// Random source

// Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
	logic [15:0] stepped;
	stepped = state >> 1;
	if (state[0])
		stepped = stepped ^ 16'hB400;
	return stepped;
endfunction

////////////////////
// Reference model

// White only when strictly above the threshold
function automatic logic [7:0] threshold_byte(
	input logic signed [31:0] value,
	input logic signed [31:0] threshold
);
	return (value > threshold) ? 8'hff : 8'h00;
endfunction

function automatic bit is_interior(input int row, input int col);
	return (row >= frame_border) && (row < frame_height - frame_border) &&
		(col >= frame_border) && (col < frame_width - frame_border);
endfunction

// Word built lane by lane from the pixel position in the frame
function automatic logic [63:0] expected_word(
	input int word,
	input logic signed [31:0] threshold,
	input logic signed [31:0] pix [frame_pixels]
);
	logic [63:0] result;
	int lane;
	int addr;
	int row;
	int col;
	result = '0;
	for (lane = 0; lane < 8; lane++) begin
		addr = word * 8 + lane;
		row = addr / frame_width;
		col = addr % frame_width;
		if (is_interior(row, col))
			result[lane * 8 +: 8] = threshold_byte(
				pix[(row - frame_border) * row_pixels + col - frame_border], threshold);
	end
	return result;
endfunction

`endif

/* tb_output_stage.sv */
`timescale 1ns/10ps

module tb_output_stage
	import out_types_pkg::*;
	import out_geom_pkg::*;
();

	localparam int test_count = 3;
	localparam int ready_timeout = 2000;
	localparam int full_timeout = 200;
	localparam int first_word = (frame_width + frame_border) >> lane_bits;
	localparam int last_word =
		((frame_height - frame_border - 1) * frame_width + frame_width - frame_border - 1) >> lane_bits;

	logic clk;
	logic reset;
	logic pixel_push;
	logic signed [pixel_width-1:0] pixel_data;
	logic pixel_full;
	logic cfg_write;
	logic [1:0] cfg_addr;
	logic [reg_width-1:0] cfg_wdata;
	logic [reg_width-1:0] cfg_rdata;
	logic frame_ready;
	logic [ram_addr_width-1:0] ram_read_addr;
	logic [ram_data_width-1:0] ram_read_data;

	// Stimulus table
	string test_name [test_count];
	int test_threshold [test_count];
	int test_gap [test_count];
	int test_written [test_count];

	logic signed [pixel_width-1:0] sent_pixels [frame_pixels];
	logic [15:0] lfsr_state;
	int error_count;
	int check_count;
	int tests_run;
	bit timed_out;

	`include "tb_output_model.svh"

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	output_stage_top u_dut (
		.clk(clk),
		.reset(reset),
		.pixel_push(pixel_push),
		.pixel_data(pixel_data),
		.pixel_full(pixel_full),
		.cfg_write(cfg_write),
		.cfg_addr(cfg_addr),
		.cfg_wdata(cfg_wdata),
		.cfg_rdata(cfg_rdata),
		.frame_ready(frame_ready),
		.ram_read_addr(ram_read_addr),
		.ram_read_data(ram_read_data)
	);

	task automatic load_table();
		test_name[0] = "frame_t128";
		test_threshold[0] = 128;
		test_gap[0] = 0;
		test_written[0] = 868;
		test_name[1] = "frame_neg5";
		test_threshold[1] = -5;
		test_gap[1] = 2;
		test_written[1] = 868;
		test_name[2] = "frame_t1000";
		test_threshold[2] = 1000;
		test_gap[2] = 1;
		test_written[2] = 868;
	endtask

	task automatic check_value(input string test, input string item,
		input logic [63:0] expected, input logic [63:0] actual);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("FAILED %s %s: expected %h, actual %h", test, item, expected, actual);
		end
	endtask

	////////////////////
	// Waits, each bounded

	task automatic wait_not_full(input string test);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (pixel_full && cycles < full_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (pixel_full) begin
			$display("Timeout in %s: pixel FIFO stayed full for %0d cycles", test, full_timeout);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	task automatic wait_frame_ready(input string test);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!frame_ready && cycles < ready_timeout) begin
			@(negedge clk);
			cycles++;
		end
		if (!frame_ready) begin
			$display("Timeout in %s: frame_ready did not rise within %0d cycles", test,
				ready_timeout);
			error_count++;
			timed_out = 1'b1;
		end
	endtask

	////////////////////
	// Bus actions

	// 12 random bits, sign extended
	task automatic draw_pixel(output logic signed [pixel_width-1:0] value);
		logic [11:0] raw;
		int b;
		raw = '0;
		for (b = 0; b < 12; b++) begin
			raw = {raw[10:0], lfsr_state[0]};
			lfsr_state = lfsr_step(lfsr_state);
		end
		value = {{20{raw[11]}}, raw};
	endtask

	task automatic push_pixel(input string test, input logic signed [pixel_width-1:0] value,
		input int gap, input bit wait_space);
		int g;
		if (wait_space)
			wait_not_full(test);
		@(posedge clk);
		pixel_push <= 1'b1;
		pixel_data <= value;
		for (g = 0; g < gap; g++) begin
			@(posedge clk);
			pixel_push <= 1'b0;
		end
	endtask

	task automatic read_reg(input cfg_reg_e addr, output logic [reg_width-1:0] value);
		@(posedge clk);
		cfg_addr <= addr;
		@(negedge clk);
		value = cfg_rdata;
	endtask

	task automatic read_ram_word(input int word, output logic [ram_data_width-1:0] value);
		@(posedge clk);
		ram_read_addr <= 16'(word);
		@(posedge clk);
		@(negedge clk);
		value = ram_read_data;
	endtask

	// Threshold write, then restart through the control register
	task automatic restart_frame(input string test, input int threshold);
		@(posedge clk);
		cfg_write <= 1'b1;
		cfg_addr <= reg_threshold;
		cfg_wdata <= threshold;
		@(posedge clk);
		cfg_addr <= reg_control;
		cfg_wdata <= 32'd1;
		@(posedge clk);
		cfg_write <= 1'b0;
		cfg_addr <= reg_threshold;
		cfg_wdata <= '0;
		@(posedge clk);
		@(negedge clk);
		check_value(test, "frame_ready after restart", 64'd0, 64'(frame_ready));
	endtask

	task automatic report_test(input string test, input int start_errors, input int start_checks);
		tests_run++;
		$display("test %s: %0d checks, %0d mismatches", test, check_count - start_checks,
			error_count - start_errors);
	endtask

	////////////////////
	// Tests

	task automatic check_after_reset();
		logic [reg_width-1:0] value;
		int start_errors;
		int start_checks;
		start_errors = error_count;
		start_checks = check_count;
		@(negedge clk);
		check_value("after_reset", "frame_ready", 64'd0, 64'(frame_ready));
		read_reg(reg_threshold, value);
		check_value("after_reset", "threshold", 64'd128, 64'(value));
		report_test("after_reset", start_errors, start_checks);
	endtask

	task automatic run_frame_test(input int idx);
		logic signed [pixel_width-1:0] value;
		logic [reg_width-1:0] status;
		logic [ram_data_width-1:0] word_data;
		int p;
		int w;
		int start_errors;
		int start_checks;
		start_errors = error_count;
		start_checks = check_count;
		restart_frame(test_name[idx], test_threshold[idx]);
		read_reg(reg_threshold, status);
		check_value(test_name[idx], "threshold", 64'($unsigned(test_threshold[idx])),
			64'(status));
		for (p = 0; p < frame_pixels && !timed_out; p++) begin
			draw_pixel(value);
			sent_pixels[p] = value;
			push_pixel(test_name[idx], value, test_gap[idx], 1'b1);
		end
		@(posedge clk);
		pixel_push <= 1'b0;
		if (!timed_out)
			wait_frame_ready(test_name[idx]);
		if (!timed_out) begin
			read_reg(reg_status, status);
			check_value(test_name[idx], "status", 64'({16'(test_written[idx]), 15'd0, 1'b1}),
				64'(status));
			for (w = first_word; w <= last_word; w++) begin
				read_ram_word(w, word_data);
				check_value(test_name[idx], $sformatf("word %0d", w),
					expected_word(w, test_threshold[idx], sent_pixels), word_data);
			end
		end
		report_test(test_name[idx], start_errors, start_checks);
	endtask

	// Frame done, so nothing drains the FIFO
	task automatic check_back_pressure();
		logic signed [pixel_width-1:0] value;
		logic [reg_width-1:0] status;
		int k;
		int start_errors;
		int start_checks;
		start_errors = error_count;
		start_checks = check_count;
		@(negedge clk);
		check_value("back_pressure", "frame_ready", 64'd1, 64'(frame_ready));
		for (k = 0; k < fifo_depth; k++) begin
			draw_pixel(value);
			push_pixel("back_pressure", value, 0, 1'b0);
		end
		@(posedge clk);
		pixel_push <= 1'b0;
		@(negedge clk);
		check_value("back_pressure", "pixel_full", 64'd1, 64'(pixel_full));
		restart_frame("back_pressure", test_threshold[test_count-1]);
		check_value("back_pressure", "pixel_full after restart", 64'd0, 64'(pixel_full));
		read_reg(reg_status, status);
		check_value("back_pressure", "pixels_written", 64'd0, 64'(status[31:16]));
		check_value("back_pressure", "status", 64'd0, 64'(status));
		report_test("back_pressure", start_errors, start_checks);
	endtask

	initial begin
		int idx;
		reset = 1'b1;
		pixel_push = 1'b0;
		pixel_data = '0;
		cfg_write = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		ram_read_addr = '0;
		lfsr_state = 16'd26;
		error_count = 0;
		check_count = 0;
		tests_run = 0;
		timed_out = 1'b0;
		load_table();
		repeat (3) @(posedge clk);
		reset <= 1'b0;

		check_after_reset();
		for (idx = 0; idx < test_count && !timed_out; idx++)
			run_frame_test(idx);
		if (!timed_out)
			check_back_pressure();

		$display("tests %0d, checks %0d, errors %0d", tests_run, check_count, error_count);
		if (error_count == 0 && !timed_out) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
